//--- hdl/lsuPkg.sv
package lsuPkg;

    localparam logic [7:0] CSR_REGION = 8'hFF;  // top address byte of the CSR bank

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } MemSize;

    typedef logic [5:0] Tag;

    // one operation as it arrives on the input channel
    typedef struct packed {
        logic        valid;
        logic        isStore;
        MemSize      size;
        logic        signExtend;
        logic [31:0] base;
        logic [31:0] offset;
        logic [31:0] storeData;
        Tag          tagDst;
    } MemOp;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        MemSize      size;
        logic [1:0]  shamt;       // byte offset inside the word
        logic        signExtend;
        Tag          tagDst;
        logic [31:0] data;        // forwarded bytes
        logic [3:0]  wmask;       // which forwarded bytes are valid
    } AGU_UOp;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] data;        // already in word lanes
        logic [3:0]  wmask;
    } ST_UOp;

    typedef struct packed {
        logic        valid;
        Tag          tagDst;
        logic [31:0] result;
    } RES_UOp;

endpackage

//--- hdl/creditFifo.sv
module creditFifo #(
    parameter type payload_t = logic [7:0],
    parameter int DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         push,
    input  payload_t                     din,
    input  logic                         pop,
    output payload_t                     dout,
    output logic                         notEmpty,
    output logic                         credit,
    output logic [$clog2(DEPTH+1)-1:0]   freeSlots
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t slots [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic doPop;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign notEmpty = count != '0;
    assign doPop = pop && notEmpty;  // popping an empty buffer is ignored
    assign dout = slots[rdPtr];
    assign freeSlots = CNT_W'(DEPTH) - count;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            credit <= 1'b0;
        end else begin
            credit <= doPop;  // one credit back per freed slot
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            count <= count + CNT_W'(push) - CNT_W'(doPop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wrPtr] <= din;
        end
    end

    // sender pushed without holding a credit
    assert property (@(posedge clk) disable iff (rst) !(push && count == CNT_W'(DEPTH)))
        else $error("creditFifo: push while full");

endmodule

//--- hdl/memOpDecode.sv
module memOpDecode import lsuPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  MemOp   op,
    input  logic   opValid,
    output logic   pop,
    input  logic   sqFull,
    input  logic   ldReady,
    output ST_UOp  stUop,
    output AGU_UOp ldUop
);

    logic [31:0] addr;
    logic [1:0]  shamt;
    logic [3:0]  sizeMask;
    logic        canIssue;

    always_comb begin
        addr = op.base + op.offset;
        shamt = addr[1:0];
        case (op.size)
            SZ_BYTE: sizeMask = 4'b0001;
            SZ_HALF: sizeMask = 4'b0011;
            default: sizeMask = 4'b1111;
        endcase
        canIssue = op.isStore ? !sqFull : ldReady;  // hold the op until its target can take it
    end

    assign pop = opValid && canIssue;

    always_ff @(posedge clk) begin
        if (rst) begin
            stUop.valid <= 1'b0;
            ldUop.valid <= 1'b0;
        end else begin
            stUop.valid <= pop && op.isStore;
            ldUop.valid <= pop && !op.isStore;
            if (pop && op.isStore) begin
                stUop.addr <= addr;
                stUop.data <= op.storeData << {shamt, 3'b000};  // move into its lanes
                stUop.wmask <= sizeMask << shamt;
            end
            if (pop && !op.isStore) begin
                ldUop.addr <= addr;
                ldUop.size <= op.size;
                ldUop.shamt <= shamt;
                ldUop.signExtend <= op.signExtend;
                ldUop.tagDst <= op.tagDst;
                ldUop.data <= '0;  // forwarding is merged in the load unit
                ldUop.wmask <= '0;
            end
        end
    end

endmodule

//--- hdl/storeQueue.sv
module storeQueue import lsuPkg::*; #(
    parameter int DEPTH = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  ST_UOp       stUop,
    output logic        full,
    input  logic [29:0] lookupAddr,
    output logic [3:0]  lookupMask,
    output logic [31:0] lookupData,
    output logic        memWe,
    output logic        csrWe,
    output logic [29:0] writeAddr,
    output logic [31:0] writeData,
    output logic [3:0]  writeMask
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    ST_UOp entries [DEPTH];
    ST_UOp head;
    logic [PTR_W-1:0] headPtr;
    logic [PTR_W-1:0] tailPtr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] nextCount;
    logic drain;
    logic headIsCsr;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head = entries[headPtr];
    assign drain = count != '0;  // head leaves every cycle it is valid
    assign nextCount = count + CNT_W'(stUop.valid) - CNT_W'(drain);
    assign full = nextCount == CNT_W'(DEPTH);  // decode's store lands one cycle later

    assign headIsCsr = head.addr[31:24] == CSR_REGION;
    assign memWe = drain && !headIsCsr;
    assign csrWe = drain && headIsCsr;
    assign writeAddr = head.addr[31:2];
    assign writeData = head.data;
    assign writeMask = head.wmask;

    // walk oldest to youngest so younger stores overwrite older bytes
    always_comb begin
        int idx;
        lookupMask = '0;
        lookupData = '0;
        for (int i = 0; i < DEPTH; i++) begin
            idx = int'(headPtr) + i;
            if (idx >= DEPTH) begin
                idx = idx - DEPTH;
            end
            if (CNT_W'(i) < count && entries[idx].valid &&
                entries[idx].addr[31:2] == lookupAddr) begin
                for (int b = 0; b < 4; b++) begin
                    if (entries[idx].wmask[b]) begin
                        lookupMask[b] = 1'b1;
                        lookupData[8*b +: 8] = entries[idx].data[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (stUop.valid) begin
                tailPtr <= nextPtr(tailPtr);
            end
            if (drain) begin
                headPtr <= nextPtr(headPtr);
            end
            count <= nextCount;
        end
    end

    always_ff @(posedge clk) begin
        if (stUop.valid) begin
            entries[tailPtr] <= stUop;
        end
    end

    // decode must have seen full in the cycle it issued this store
    assert property (@(posedge clk) disable iff (rst) stUop.valid |-> count < CNT_W'(DEPTH))
        else $error("storeQueue: enqueue while full");

endmodule

//--- hdl/loadStoreUnit.sv
module loadStoreUnit import lsuPkg::*; #(
    parameter int RES_DEPTH = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  AGU_UOp                            ldUop,
    output logic                              ready,
    input  logic [$clog2(RES_DEPTH+1)-1:0]    resFree,
    output logic                              memRe,
    output logic [29:0]                       memReadAddr,
    input  logic [31:0]                       memReadData,
    input  logic [31:0]                       csrReadData,
    input  logic [3:0]                        lookupMask,
    input  logic [31:0]                       lookupData,
    output RES_UOp                            resUop
);

    localparam int FREE_W = $clog2(RES_DEPTH + 1);

    AGU_UOp stage0;
    AGU_UOp stage1;
    AGU_UOp fwdUop;
    logic stage1Csr;
    logic bypass;
    logic [FREE_W-1:0] inFlight;
    logic [31:0] fillData;
    logic [31:0] merged;
    logic [7:0] byteVal;
    logic [15:0] halfVal;
    logic [31:0] result;

    always_comb begin
        fwdUop = ldUop;
        fwdUop.data = lookupData;
        fwdUop.wmask = lookupMask;
    end

    // all four bytes forwarded and nothing older waiting for memory
    assign bypass = ldUop.valid && lookupMask == 4'b1111 && !stage0.valid;

    // stage 0 always moves on, so only the result FIFO can hold loads back
    assign inFlight = FREE_W'(ldUop.valid) + FREE_W'(stage0.valid) + FREE_W'(stage1.valid);
    assign ready = resFree > inFlight;

    assign memRe = stage0.valid;
    assign memReadAddr = stage0.addr[31:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            stage0.valid <= 1'b0;
            stage1.valid <= 1'b0;
        end else begin
            stage0.valid <= 1'b0;
            stage1.valid <= 1'b0;
            if (stage0.valid) begin
                stage1 <= stage0;
                stage1Csr <= stage0.addr[31:24] == CSR_REGION;
            end
            if (ldUop.valid) begin
                if (bypass) begin
                    stage1 <= fwdUop;
                    stage1Csr <= 1'b0;  // every byte comes from the store queue
                end else begin
                    stage0 <= fwdUop;
                end
            end
        end
    end

    always_comb begin
        fillData = stage1Csr ? csrReadData : memReadData;
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = stage1.wmask[b] ? stage1.data[8*b +: 8] : fillData[8*b +: 8];
        end
        byteVal = merged[{stage1.shamt, 3'b000} +: 8];
        halfVal = stage1.shamt[1] ? merged[31:16] : merged[15:0];
        case (stage1.size)
            SZ_BYTE: result = {{24{stage1.signExtend & byteVal[7]}}, byteVal};
            SZ_HALF: result = {{16{stage1.signExtend & halfVal[15]}}, halfVal};
            default: result = merged;
        endcase
    end

    always_comb begin
        resUop.valid = stage1.valid;
        resUop.tagDst = stage1.tagDst;
        resUop.result = result;
    end

    // the load leaving stage 0 is the one found in stage 1 next cycle
    assert property (@(posedge clk) disable iff (rst)
        stage0.valid |=> stage1.valid && stage1.tagDst == $past(stage0.tagDst))
        else $error("loadStoreUnit: two loads entered stage 1");

endmodule

//--- hdl/dataMemory.sv
module dataMemory #(
    parameter int MEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        re,
    input  logic [29:0] readAddr,
    output logic [31:0] readData,
    output logic [31:0] csrReadData,
    input  logic        we,
    input  logic        csrWe,
    input  logic [29:0] writeAddr,
    input  logic [31:0] writeData,
    input  logic [3:0]  writeMask
);

    localparam int AW = $clog2(MEM_WORDS);

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] csr [4];  // indexed by the low word address bits

    always_ff @(posedge clk) begin
        if (re) begin
            readData <= mem[readAddr[AW-1:0]];
            csrReadData <= csr[readAddr[1:0]];  // same latency as memory
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (we && writeMask[b]) begin
                mem[writeAddr[AW-1:0]][8*b +: 8] <= writeData[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (csrWe && writeMask[b]) begin
                csr[writeAddr[1:0]][8*b +: 8] <= writeData[8*b +: 8];
            end
        end
    end

endmodule

//--- hdl/lsuTop.sv
module lsuTop import lsuPkg::*; #(
    parameter int IN_DEPTH  = 4,
    parameter int RES_DEPTH = 4,
    parameter int SQ_DEPTH  = 4,
    parameter int MEM_WORDS = 256
) (
    input  logic   clk,
    input  logic   rst,
    input  MemOp   inOp,
    output logic   inCredit,
    output RES_UOp resOut,
    input  logic   resCredit
);

    localparam int RC_W = $clog2(RES_DEPTH + 1);

    MemOp headOp;
    logic headValid;
    logic decPop;
    ST_UOp stUop;
    AGU_UOp ldUop;
    logic sqFull;
    logic ldReady;
    logic [3:0] lookupMask;
    logic [31:0] lookupData;
    logic memWe;
    logic csrWe;
    logic [29:0] writeAddr;
    logic [31:0] writeData;
    logic [3:0] writeMask;
    logic memRe;
    logic [29:0] memReadAddr;
    logic [31:0] memReadData;
    logic [31:0] csrReadData;
    RES_UOp resUop;
    RES_UOp resHead;
    logic resAvail;
    logic resPop;
    logic [RC_W-1:0] resFree;
    logic [RC_W-1:0] resCredits;

    creditFifo #(.payload_t(MemOp), .DEPTH(IN_DEPTH)) inFifo (
        .clk(clk), .rst(rst), .push(inOp.valid), .din(inOp), .pop(decPop),
        .dout(headOp), .notEmpty(headValid), .credit(inCredit), .freeSlots()
    );

    memOpDecode decode (
        .clk(clk), .rst(rst), .op(headOp), .opValid(headValid), .pop(decPop),
        .sqFull(sqFull), .ldReady(ldReady), .stUop(stUop), .ldUop(ldUop)
    );

    storeQueue #(.DEPTH(SQ_DEPTH)) sq (
        .clk(clk), .rst(rst), .stUop(stUop), .full(sqFull),
        .lookupAddr(ldUop.addr[31:2]), .lookupMask(lookupMask), .lookupData(lookupData),
        .memWe(memWe), .csrWe(csrWe), .writeAddr(writeAddr), .writeData(writeData),
        .writeMask(writeMask)
    );

    loadStoreUnit #(.RES_DEPTH(RES_DEPTH)) lsu (
        .clk(clk), .rst(rst), .ldUop(ldUop), .ready(ldReady), .resFree(resFree),
        .memRe(memRe), .memReadAddr(memReadAddr), .memReadData(memReadData),
        .csrReadData(csrReadData), .lookupMask(lookupMask), .lookupData(lookupData),
        .resUop(resUop)
    );

    dataMemory #(.MEM_WORDS(MEM_WORDS)) dmem (
        .clk(clk), .re(memRe), .readAddr(memReadAddr), .readData(memReadData),
        .csrReadData(csrReadData), .we(memWe), .csrWe(csrWe), .writeAddr(writeAddr),
        .writeData(writeData), .writeMask(writeMask)
    );

    creditFifo #(.payload_t(RES_UOp), .DEPTH(RES_DEPTH)) resFifo (
        .clk(clk), .rst(rst), .push(resUop.valid), .din(resUop), .pop(resPop),
        .dout(resHead), .notEmpty(resAvail), .credit(), .freeSlots(resFree)
    );

    // present the head only while the testbench has room for it
    assign resPop = resAvail && resCredits != '0;

    always_comb begin
        resOut = resHead;
        resOut.valid = resPop;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resCredits <= RC_W'(RES_DEPTH);
        end else begin
            resCredits <= resCredits + RC_W'(resCredit) - RC_W'(resPop);
        end
    end

endmodule

//--- dv/tbClock.sv
module tbClock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;  // 20 unit period

endmodule

//--- dv/lsuTb.sv
module lsuTb import lsuPkg::*; ();

    localparam int IN_DEPTH  = 4;
    localparam int RES_DEPTH = 4;
    localparam int SQ_DEPTH  = 4;
    localparam int MEM_WORDS = 256;
    localparam int TIMEOUT   = 3000;  // cycles for the whole run

    logic   clk;
    logic   rst;
    MemOp   inOp;
    logic   inCredit;
    RES_UOp resOut;
    logic   resCredit;

    MemOp       ops[$];
    RES_UOp     expected[$];
    logic [7:0] memModel [1024];
    logic [7:0] csrModel [16];  // four words, byte addressed
    integer     seed = 32'he858;
    int         inCredits;
    int         outstanding;     // results received, credit not yet returned
    int         gap;
    int         cycle;
    int         quiet;
    int         nextOp;

    tbClock clkGen (.clk(clk));

    lsuTop #(
        .IN_DEPTH(IN_DEPTH),
        .RES_DEPTH(RES_DEPTH),
        .SQ_DEPTH(SQ_DEPTH),
        .MEM_WORDS(MEM_WORDS)
    ) UUT (
        .clk(clk),
        .rst(rst),
        .inOp(inOp),
        .inCredit(inCredit),
        .resOut(resOut),
        .resCredit(resCredit)
    );

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkResult(input RES_UOp got, input RES_UOp exp);
        if (got.tagDst !== exp.tagDst || got.result !== exp.result) begin
            abortRun($sformatf("ERROR at time %0t: tag %0d result %h, expected tag %0d result %h",
                $time, got.tagDst, got.result, exp.tagDst, exp.result));
        end
    endtask

    task automatic checkCredits(input string what, input int got, input int low, input int high);
        if (got < low || got > high) begin
            abortRun($sformatf("ERROR at time %0t: %s is %0d, expected %0d to %0d",
                $time, what, got, low, high));
        end
    endtask

    function automatic logic [7:0] readModelByte(input logic [31:0] addr);
        if (addr[31:24] == CSR_REGION) begin
            return csrModel[addr[3:0]];
        end
        return memModel[addr[9:0]];  // memory wraps at MEM_WORDS words
    endfunction

    function automatic void writeModelByte(input logic [31:0] addr, input logic [7:0] val);
        if (addr[31:24] == CSR_REGION) begin
            csrModel[addr[3:0]] = val;
        end else begin
            memModel[addr[9:0]] = val;
        end
    endfunction

    function automatic logic [31:0] loadValue(input logic [31:0] addr, input int nBytes,
                                              input logic signExt);
        logic [31:0] raw;
        raw = '0;
        for (int b = 0; b < nBytes; b++) begin
            raw[8*b +: 8] = readModelByte(addr + 32'(b));
        end
        if (nBytes == 1) begin
            return signExt ? {{24{raw[7]}}, raw[7:0]} : raw;
        end
        if (nBytes == 2) begin
            return signExt ? {{16{raw[15]}}, raw[15:0]} : raw;
        end
        return raw;
    endfunction

    // read the operations and run them through the model in program order
    task automatic loadOps();
        int fd;
        int n;
        int nBytes;
        string line;
        logic [31:0] st;
        logic [31:0] sz;
        logic [31:0] sx;
        logic [31:0] base;
        logic [31:0] offset;
        logic [31:0] data;
        logic [31:0] tag;
        logic [31:0] addr;
        MemOp op;
        RES_UOp res;
        fd = $fopen("dv/lsuInput.dat", "r");
        if (fd == 0) begin
            abortRun("could not open the input file dv/lsuInput.dat");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h", st, sz, sx, base, offset, data, tag);
            if (n != 7) begin
                abortRun($sformatf("could not parse input line: %s", line));
            end
            op = '0;
            op.valid = 1'b1;
            op.isStore = st[0];
            op.size = MemSize'(sz[1:0]);
            op.signExtend = sx[0];
            op.base = base;
            op.offset = offset;
            op.storeData = data;
            op.tagDst = Tag'(tag[5:0]);
            ops.push_back(op);
            addr = base + offset;
            nBytes = (sz == 0) ? 1 : (sz == 1) ? 2 : 4;
            if (st[0]) begin
                for (int b = 0; b < nBytes; b++) begin
                    writeModelByte(addr + 32'(b), data[8*b +: 8]);
                end
            end else begin
                res = '0;
                res.valid = 1'b1;
                res.tagDst = Tag'(tag[5:0]);
                res.result = loadValue(addr, nBytes, sx[0]);
                expected.push_back(res);
            end
        end
        $fclose(fd);
    endtask

    function automatic logic allDone();
        return nextOp == ops.size() && expected.size() == 0 && outstanding == 0 && quiet >= 8;
    endfunction

    initial begin
        rst = 1'b1;
        inOp = '0;
        resCredit = 1'b0;
        inCredits = IN_DEPTH;
        outstanding = 0;
        gap = 0;
        cycle = 0;
        quiet = 0;
        nextOp = 0;
        loadOps();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        while (!allDone() && cycle < TIMEOUT) begin
            @(negedge clk);
            cycle++;
            quiet++;
            if (inCredit) begin
                inCredits++;
                quiet = 0;
                checkCredits("input credits held", inCredits, 0, IN_DEPTH);
            end
            if (resOut.valid) begin
                outstanding++;
                quiet = 0;
                checkCredits("results without a returned credit", outstanding, 1, RES_DEPTH);
                if (expected.size() == 0) begin
                    abortRun("a load result arrived that matches no load of the input file");
                end
                checkResult(resOut, expected.pop_front());
            end
            inOp = '0;
            if (nextOp < ops.size() && inCredits > 0) begin
                inOp = ops[nextOp];
                nextOp++;
                inCredits--;
                quiet = 0;
            end
            resCredit = 1'b0;
            if (outstanding > 0) begin
                if (gap == 0) begin
                    resCredit = 1'b1;
                    outstanding--;
                    gap = $random(seed) & 3;  // random hold before the next credit
                    quiet = 0;
                end else begin
                    gap--;
                end
            end
        end

        if (allDone()) begin
            checkCredits("input credits held at the end", inCredits, IN_DEPTH, IN_DEPTH);
            $display("RESULT: PASS");
            $finish;
        end else begin
            abortRun($sformatf("timeout after %0d cycles, %0d of %0d ops sent, %0d loads missing",
                cycle, nextOp, ops.size(), expected.size()));
        end
    end

endmodule

//--- lsuSubsys.f
hdl/lsuPkg.sv
hdl/creditFifo.sv
hdl/memOpDecode.sv
hdl/storeQueue.sv
hdl/loadStoreUnit.sv
hdl/dataMemory.sv
hdl/lsuTop.sv
dv/tbClock.sv
dv/lsuTb.sv

//--- build.sh
#!/usr/bin/env bash
# compile and run the lsuSubsys testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal --top-module lsuTb \
    -f lsuSubsys.f -o lsuSim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/lsuSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "RESULT: PASS" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- dv/lsuInput.dat
# isStore size(0 byte 1 half 2 word) signExtend base offset storeData tag, all hex
# expected load results come from the testbench model
1 2 0 00000100 00000000 11223344 00
1 2 0 00000100 00000004 8899aabb 00
1 2 0 00000000 00000010 cafef00d 00
1 0 0 00000100 00000008 000000f0 00
1 0 0 00000100 00000009 00000012 00
1 1 0 00000100 0000000a 00009abc 00
1 2 0 ff000000 00000010 deadbeef 00
1 2 0 ff000000 00000004 01234567 00
0 2 0 00000100 00000000 00000000 01
0 0 1 00000100 00000004 00000000 02
0 0 0 00000100 00000007 00000000 03
0 1 1 00000100 00000006 00000000 04
0 1 0 00000100 00000004 00000000 05
0 2 0 00000100 00000008 00000000 06
0 0 1 00000100 00000008 00000000 07
0 2 0 ff000000 00000010 00000000 08
0 2 0 00000000 00000010 00000000 09
0 1 1 ff000000 00000006 00000000 0a
1 2 0 00000200 00000000 a5a5c3c3 00
0 2 0 00000200 00000000 00000000 0b
1 0 0 00000104 00000001 0000007e 00
0 2 0 00000104 00000000 00000000 0c
1 1 0 00000200 00000002 0000beef 00
0 1 1 00000200 00000002 00000000 0d
0 0 0 00000000 00000013 00000000 0e
0 2 0 00000200 00000000 00000000 0f
1 2 0 ff000000 0000000c 0badf00d 00
0 2 0 ff00000c 00000000 00000000 10
0 1 0 ff000000 00000012 00000000 11
0 2 0 00000300 fffffe00 00000000 12
